/* rsPkg.sv */
`default_nettype none

package rsPkg;

    localparam int kTagWidth = 6;
    localparam int kDataWidth = 32;
    localparam int kAluOpWidth = 4;
    localparam int kEntries = 16;
    localparam int kEntryIdxWidth = 4;
    localparam int kBuses = 4;

    // lower bus index wins when buses share a tag
    localparam int kBusAlu = 0;
    localparam int kBusMul = 1;
    localparam int kBusDiv = 2;
    localparam int kBusLoad = 3;

    typedef logic [kTagWidth-1:0] tagT;
    typedef logic [kDataWidth-1:0] dataT;
    typedef logic [kAluOpWidth-1:0] aluOpT;
    typedef logic [kEntries-1:0] entryMaskT;
    typedef logic [kEntryIdxWidth-1:0] entryIdxT;

    // a zero mask returns index 0
    function automatic entryIdxT lowestSetIndex(input entryMaskT mask);
        entryIdxT idx;
        idx = '0;
        for (int i = kEntries - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = entryIdxT'(i);
            end
        end
        return idx;
    endfunction

    // returns {hit, data} for the highest priority bus carrying tag
    function automatic logic [kDataWidth:0] busLookup(
        input tagT tag,
        input logic [kBuses-1:0] valid,
        input tagT tags [kBuses],
        input dataT data [kBuses]
    );
        logic [kBuses-1:0] hit;
        logic [kDataWidth:0] res;
        for (int b = 0; b < kBuses; b++) begin
            hit[b] = valid[b] && (tags[b] == tag);
        end
        if (hit[kBusAlu]) begin
            res = {1'b1, data[kBusAlu]};
        end else if (hit[kBusMul]) begin
            res = {1'b1, data[kBusMul]};
        end else if (hit[kBusDiv]) begin
            res = {1'b1, data[kBusDiv]};
        end else if (hit[kBusLoad]) begin
            res = {1'b1, data[kBusLoad]};
        end else begin
            res = '0;
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* operandCapture.sv */
`timescale 1ns/1ps
`default_nettype none

module operandCapture (
    input  rsPkg::tagT               src1Tag,
    input  rsPkg::tagT               src2Tag,
    input  rsPkg::dataT              src1Data,
    input  rsPkg::dataT              src2Data,
    input  logic                     src1Ready,
    input  logic                     src2Ready,
    input  logic [rsPkg::kBuses-1:0] resultValid,
    input  rsPkg::tagT               resultTag [rsPkg::kBuses],
    input  rsPkg::dataT              resultData [rsPkg::kBuses],
    output rsPkg::dataT              cap1Data,
    output rsPkg::dataT              cap2Data,
    output logic                     cap1Ready,
    output logic                     cap2Ready
);
    import rsPkg::*;

    logic [kDataWidth:0] look1;
    logic [kDataWidth:0] look2;
    logic                bypass1;
    logic                bypass2;

    // same-cycle broadcast seen at dispatch
    assign look1 = busLookup(src1Tag, resultValid, resultTag, resultData);
    assign look2 = busLookup(src2Tag, resultValid, resultTag, resultData);

    // only a waiting source takes the bus value
    assign bypass1 = !src1Ready && look1[kDataWidth];
    assign bypass2 = !src2Ready && look2[kDataWidth];

    always_comb begin
        cap1Ready = src1Ready;
        cap1Data = src1Data;
        if (bypass1) begin
            cap1Ready = 1'b1;
            cap1Data = look1[kDataWidth-1:0];
        end
    end

    always_comb begin
        cap2Ready = src2Ready;
        cap2Data = src2Data;
        if (bypass2) begin
            cap2Ready = 1'b1;
            cap2Data = look2[kDataWidth-1:0];
        end
    end

endmodule

`default_nettype wire

/* rsEntryArray.sv */
`timescale 1ns/1ps
`default_nettype none

module rsEntryArray (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dispatchValid,
    input  rsPkg::dataT              cap1Data,
    input  rsPkg::dataT              cap2Data,
    input  logic                     cap1Ready,
    input  logic                     cap2Ready,
    input  rsPkg::tagT               src1Tag,
    input  rsPkg::tagT               src2Tag,
    input  rsPkg::tagT               destTag,
    input  rsPkg::aluOpT             aluOp,
    input  rsPkg::dataT              imm,
    input  logic                     isLoad,
    input  logic [rsPkg::kBuses-1:0] resultValid,
    input  rsPkg::tagT               resultTag [rsPkg::kBuses],
    input  rsPkg::dataT              resultData [rsPkg::kBuses],
    input  rsPkg::entryMaskT         issueGrant,
    output rsPkg::entryMaskT         busy,
    output rsPkg::entryMaskT         src1Ok,
    output rsPkg::entryMaskT         src2Ok,
    output rsPkg::tagT               entDest [rsPkg::kEntries],
    output rsPkg::aluOpT             entAluOp [rsPkg::kEntries],
    output rsPkg::dataT              entImm [rsPkg::kEntries],
    output rsPkg::dataT              entSrc1 [rsPkg::kEntries],
    output rsPkg::dataT              entSrc2 [rsPkg::kEntries],
    output rsPkg::entryMaskT         entLoad,
    output logic                     rsFull
);
    import rsPkg::*;

    tagT                 entSrc1Tag [kEntries];
    tagT                 entSrc2Tag [kEntries];
    logic [kDataWidth:0] look1 [kEntries];
    logic [kDataWidth:0] look2 [kEntries];
    entryMaskT           wake1;
    entryMaskT           wake2;
    entryMaskT           allocMask;
    entryIdxT            allocIdx;
    logic                doAlloc;

    assign rsFull = &busy;
    assign doAlloc = dispatchValid && !rsFull; // dispatch into full array is lost
    assign allocIdx = lowestSetIndex(~busy);
    assign allocMask = doAlloc ? (entryMaskT'(1) << allocIdx) : '0;

    // tag match against every bus, per waiting operand
    always_comb begin
        for (int e = 0; e < kEntries; e++) begin
            look1[e] = busLookup(entSrc1Tag[e], resultValid, resultTag, resultData);
            look2[e] = busLookup(entSrc2Tag[e], resultValid, resultTag, resultData);
            wake1[e] = busy[e] && !src1Ok[e] && look1[e][kDataWidth];
            wake2[e] = busy[e] && !src2Ok[e] && look2[e][kDataWidth];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= '0;
            src1Ok <= '0;
            src2Ok <= '0;
        end else begin
            for (int e = 0; e < kEntries; e++) begin
                if (allocMask[e]) begin
                    busy[e] <= 1'b1;
                    src1Ok[e] <= cap1Ready;
                    src2Ok[e] <= cap2Ready;
                end else begin
                    if (issueGrant[e]) begin
                        busy[e] <= 1'b0; // freed as it leaves
                        src1Ok[e] <= 1'b0;
                        src2Ok[e] <= 1'b0;
                    end else begin
                        if (wake1[e]) begin
                            src1Ok[e] <= 1'b1;
                        end
                        if (wake2[e]) begin
                            src2Ok[e] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < kEntries; e++) begin
            if (allocMask[e]) begin
                entSrc1Tag[e] <= src1Tag;
                entSrc2Tag[e] <= src2Tag;
                entDest[e] <= destTag;
                entAluOp[e] <= aluOp;
                entImm[e] <= imm;
                entLoad[e] <= isLoad;
                entSrc1[e] <= cap1Data;
                entSrc2[e] <= cap2Data;
            end else begin
                if (wake1[e]) begin
                    entSrc1[e] <= look1[e][kDataWidth-1:0];
                end
                if (wake2[e]) begin
                    entSrc2[e] <= look2[e][kDataWidth-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* issueSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module issueSelect (
    input  logic             clk,
    input  logic             reset,
    input  rsPkg::entryMaskT busy,
    input  rsPkg::entryMaskT src1Ok,
    input  rsPkg::entryMaskT src2Ok,
    input  rsPkg::entryMaskT entLoad,
    input  rsPkg::tagT       entDest [rsPkg::kEntries],
    input  rsPkg::aluOpT     entAluOp [rsPkg::kEntries],
    input  rsPkg::dataT      entImm [rsPkg::kEntries],
    input  rsPkg::dataT      entSrc1 [rsPkg::kEntries],
    input  rsPkg::dataT      entSrc2 [rsPkg::kEntries],
    output rsPkg::entryMaskT issueGrant,
    output logic             issueValid,
    output logic             issueToMem,
    output rsPkg::tagT       issueDest,
    output rsPkg::aluOpT     issueAluOp,
    output rsPkg::dataT      issueImm,
    output rsPkg::dataT      issueSrc1,
    output rsPkg::dataT      issueSrc2
);
    import rsPkg::*;

    entryMaskT readyMask;
    entryIdxT  pick;
    logic      anyReady;

    assign readyMask = busy & src1Ok & src2Ok;
    assign anyReady = |readyMask;
    assign pick = lowestSetIndex(readyMask); // lowest index first, not oldest
    assign issueGrant = anyReady ? (entryMaskT'(1) << pick) : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issueValid <= 1'b0;
            issueToMem <= 1'b0;
            issueDest <= '0;
            issueAluOp <= '0;
            issueImm <= '0;
            issueSrc1 <= '0;
            issueSrc2 <= '0;
        end else begin
            issueValid <= anyReady;
            if (anyReady) begin
                issueToMem <= entLoad[pick]; // load goes to memory path
                issueDest <= entDest[pick];
                issueAluOp <= entAluOp[pick];
                issueImm <= entImm[pick];
                issueSrc1 <= entSrc1[pick];
                issueSrc2 <= entSrc2[pick];
            end
        end
    end

endmodule

`default_nettype wire

/* reservationStation.sv */
`timescale 1ns/1ps
`default_nettype none

module reservationStation (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dispatchValid,
    input  rsPkg::tagT               src1Tag,
    input  rsPkg::dataT              src1Data,
    input  logic                     src1Ready,
    input  rsPkg::tagT               src2Tag,
    input  rsPkg::dataT              src2Data,
    input  logic                     src2Ready,
    input  rsPkg::tagT               destTag,
    input  rsPkg::aluOpT             aluOp,
    input  rsPkg::dataT              imm,
    input  logic                     isLoad,
    input  logic [rsPkg::kBuses-1:0] resultValid,
    input  rsPkg::tagT               resultTag [rsPkg::kBuses],
    input  rsPkg::dataT              resultData [rsPkg::kBuses],
    output logic                     rsFull,
    output logic                     issueValid,
    output logic                     issueToMem,
    output rsPkg::tagT               issueDest,
    output rsPkg::aluOpT             issueAluOp,
    output rsPkg::dataT              issueImm,
    output rsPkg::dataT              issueSrc1,
    output rsPkg::dataT              issueSrc2
);
    import rsPkg::*;

    dataT      cap1Data;
    dataT      cap2Data;
    logic      cap1Ready;
    logic      cap2Ready;
    entryMaskT busy;
    entryMaskT src1Ok;
    entryMaskT src2Ok;
    entryMaskT entLoad;
    entryMaskT issueGrant;
    tagT       entDest [kEntries];
    aluOpT     entAluOp [kEntries];
    dataT      entImm [kEntries];
    dataT      entSrc1 [kEntries];
    dataT      entSrc2 [kEntries];

    operandCapture capture (
        .src1Tag     (src1Tag),
        .src2Tag     (src2Tag),
        .src1Data    (src1Data),
        .src2Data    (src2Data),
        .src1Ready   (src1Ready),
        .src2Ready   (src2Ready),
        .resultValid (resultValid),
        .resultTag   (resultTag),
        .resultData  (resultData),
        .cap1Data    (cap1Data),
        .cap2Data    (cap2Data),
        .cap1Ready   (cap1Ready),
        .cap2Ready   (cap2Ready)
    );

    rsEntryArray entries (
        .clk           (clk),
        .reset         (reset),
        .dispatchValid (dispatchValid),
        .cap1Data      (cap1Data),
        .cap2Data      (cap2Data),
        .cap1Ready     (cap1Ready),
        .cap2Ready     (cap2Ready),
        .src1Tag       (src1Tag),
        .src2Tag       (src2Tag),
        .destTag       (destTag),
        .aluOp         (aluOp),
        .imm           (imm),
        .isLoad        (isLoad),
        .resultValid   (resultValid),
        .resultTag     (resultTag),
        .resultData    (resultData),
        .issueGrant    (issueGrant),
        .busy          (busy),
        .src1Ok        (src1Ok),
        .src2Ok        (src2Ok),
        .entDest       (entDest),
        .entAluOp      (entAluOp),
        .entImm        (entImm),
        .entSrc1       (entSrc1),
        .entSrc2       (entSrc2),
        .entLoad       (entLoad),
        .rsFull        (rsFull)
    );

    issueSelect select (
        .clk        (clk),
        .reset      (reset),
        .busy       (busy),
        .src1Ok     (src1Ok),
        .src2Ok     (src2Ok),
        .entLoad    (entLoad),
        .entDest    (entDest),
        .entAluOp   (entAluOp),
        .entImm     (entImm),
        .entSrc1    (entSrc1),
        .entSrc2    (entSrc2),
        .issueGrant (issueGrant),
        .issueValid (issueValid),
        .issueToMem (issueToMem),
        .issueDest  (issueDest),
        .issueAluOp (issueAluOp),
        .issueImm   (issueImm),
        .issueSrc1  (issueSrc1),
        .issueSrc2  (issueSrc2)
    );

endmodule

`default_nettype wire

/* tbReservationStation.sv */
`timescale 1ns/1ps
`default_nettype none

module tbReservationStation;
    import rsPkg::*;

    localparam int kTimeout = 40; // cycles any one wait may take

    logic              clk;
    logic              reset;
    logic              dispatchValid;
    tagT               src1Tag;
    dataT              src1Data;
    logic              src1Ready;
    tagT               src2Tag;
    dataT              src2Data;
    logic              src2Ready;
    tagT               destTag;
    aluOpT             aluOp;
    dataT              imm;
    logic              isLoad;
    logic [kBuses-1:0] resultValid;
    tagT               resultTag [kBuses];
    dataT              resultData [kBuses];
    logic              rsFull;
    logic              issueValid;
    logic              issueToMem;
    tagT               issueDest;
    aluOpT             issueAluOp;
    dataT              issueImm;
    dataT              issueSrc1;
    dataT              issueSrc2;

    int mismatchCount;
    int timeoutCount;
    int otherCount;

    reservationStation uut (
        .clk           (clk),
        .reset         (reset),
        .dispatchValid (dispatchValid),
        .src1Tag       (src1Tag),
        .src1Data      (src1Data),
        .src1Ready     (src1Ready),
        .src2Tag       (src2Tag),
        .src2Data      (src2Data),
        .src2Ready     (src2Ready),
        .destTag       (destTag),
        .aluOp         (aluOp),
        .imm           (imm),
        .isLoad        (isLoad),
        .resultValid   (resultValid),
        .resultTag     (resultTag),
        .resultData    (resultData),
        .rsFull        (rsFull),
        .issueValid    (issueValid),
        .issueToMem    (issueToMem),
        .issueDest     (issueDest),
        .issueAluOp    (issueAluOp),
        .issueImm      (issueImm),
        .issueSrc1     (issueSrc1),
        .issueSrc2     (issueSrc2)
    );

    always #50 clk = ~clk;

    task automatic reportMismatch(input string testName, input string field,
                                  input logic [31:0] expected, input logic [31:0] actual);
        $display("Error %0s %0s: expected %h, actual %h", testName, field, expected, actual);
        mismatchCount++;
    endtask

    task automatic checkFieldCount(input int got, input int want, input string line);
        if (got != want) begin
            $display("Malformed stimulus line, %0d of %0d fields read: %0s", got, want, line);
            otherCount++;
        end
    endtask

    // advance to the next falling edge and drop the one-cycle strobes
    task automatic stepCycle();
        @(negedge clk);
        dispatchValid = 1'b0;
        resultValid = '0;
    endtask

    task automatic waitIssue(output int waited);
        waited = 0;
        while (!issueValid && waited < kTimeout) begin
            @(negedge clk);
            waited++;
        end
    endtask

    // end of the name token that follows the command letter
    function automatic int nameEnd(input string s);
        int pos;
        pos = 2;
        while (pos < s.len() && s.getc(pos) != " ") begin
            pos++;
        end
        return pos;
    endfunction

    initial begin
        int          fd;
        int          n;
        int          pos;
        int          waited;
        byte         cmd;
        string       line;
        string       testName;
        string       rest;
        logic [31:0] f [10];
        clk = 1'b0;
        reset = 1'b1;
        dispatchValid = 1'b0;
        src1Tag = '0;
        src1Data = '0;
        src1Ready = 1'b0;
        src2Tag = '0;
        src2Data = '0;
        src2Ready = 1'b0;
        destTag = '0;
        aluOp = '0;
        imm = '0;
        isLoad = 1'b0;
        resultValid = '0;
        for (int b = 0; b < kBuses; b++) begin
            resultTag[b] = '0;
            resultData[b] = '0;
        end
        mismatchCount = 0;
        timeoutCount = 0;
        otherCount = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        fd = $fopen("rsStimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file rsStimulus.txt");
            otherCount++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                cmd = line.getc(0);
                pos = nameEnd(line);
                testName = line.substr(2, pos - 1);
                rest = line.substr(pos, line.len() - 1);
                case (cmd)
                    "D": begin
                        n = $sscanf(line.substr(1, line.len() - 1),
                                    "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                    f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                        checkFieldCount(n, 10, line);
                        src1Tag = tagT'(f[0]);
                        src1Data = f[1];
                        src1Ready = f[2][0];
                        src2Tag = tagT'(f[3]);
                        src2Data = f[4];
                        src2Ready = f[5][0];
                        destTag = tagT'(f[6]);
                        aluOp = aluOpT'(f[7]);
                        imm = f[8];
                        isLoad = f[9][0];
                        dispatchValid = 1'b1;
                        stepCycle();
                    end
                    "B": begin // held until the next step, so it can share a dispatch cycle
                        n = $sscanf(line.substr(1, line.len() - 1),
                                    "%h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                                    f[4], f[5], f[6], f[7], f[8]);
                        checkFieldCount(n, 9, line);
                        resultValid = f[0][kBuses-1:0];
                        for (int b = 0; b < kBuses; b++) begin
                            resultTag[b] = tagT'(f[1 + 2 * b]);
                            resultData[b] = f[2 + 2 * b];
                        end
                    end
                    "I": begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%d", f[0]);
                        checkFieldCount(n, 1, line);
                        repeat (f[0]) stepCycle();
                    end
                    "C": begin
                        n = $sscanf(rest, "%h %h", f[0], f[1]);
                        checkFieldCount(n, 2, line);
                        if (issueValid !== f[0][0]) begin
                            reportMismatch(testName, "issueValid", f[0], issueValid);
                        end
                        if (rsFull !== f[1][0]) begin
                            reportMismatch(testName, "rsFull", f[1], rsFull);
                        end
                    end
                    "E": begin
                        n = $sscanf(rest, "%d %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                                    f[4], f[5], f[6]);
                        checkFieldCount(n, 7, line);
                        waitIssue(waited);
                        if (!issueValid) begin
                            $display("Timeout: test %0s never issued within %0d cycles",
                                     testName, kTimeout);
                            timeoutCount++;
                        end else begin
                            if (waited != f[0]) begin
                                reportMismatch(testName, "latency", f[0], waited);
                            end
                            if (issueDest !== f[1][kTagWidth-1:0]) begin
                                reportMismatch(testName, "issueDest", f[1], issueDest);
                            end
                            if (issueAluOp !== f[2][kAluOpWidth-1:0]) begin
                                reportMismatch(testName, "issueAluOp", f[2], issueAluOp);
                            end
                            if (issueImm !== f[3]) begin
                                reportMismatch(testName, "issueImm", f[3], issueImm);
                            end
                            if (issueToMem !== f[4][0]) begin
                                reportMismatch(testName, "issueToMem", f[4], issueToMem);
                            end
                            if (issueSrc1 !== f[5]) begin
                                reportMismatch(testName, "issueSrc1", f[5], issueSrc1);
                            end
                            if (issueSrc2 !== f[6]) begin
                                reportMismatch(testName, "issueSrc2", f[6], issueSrc2);
                            end
                        end
                        stepCycle(); // issued instruction taken
                    end
                    "#", "\n", "\r": begin
                    end
                    default: begin
                        $display("Unknown command in stimulus line: %0s", line);
                        otherCount++;
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("Summary: %0d value errors, %0d timeouts, %0d other errors",
                 mismatchCount, timeoutCount, otherCount);
        if (mismatchCount + timeoutCount + otherCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rsStimulus.txt */
# D s1Tag s1Data s1Rdy s2Tag s2Data s2Rdy dest aluOp imm isLoad | B mask tag0 data0 .. tag3 data3
# I cycles | C name issueValid rsFull | E name latency dest aluOp imm isLoad src1 src2 (hex)
C reset0 0 0
I 4
C reset1 0 0
D 01 11111111 1 02 22222222 1 05 3 0000abcd 0
E readyAlu 1 05 3 0000abcd 0 11111111 22222222
D 03 33333333 1 04 44444444 1 06 7 ffff0010 1
E readyLoad 1 06 7 ffff0010 1 33333333 44444444
D 0a 0 0 00 2 1 11 1 10 0
D 00 3 1 0b 0 0 12 2 20 0
D 0c 0 0 00 4 1 13 3 30 0
D 00 5 1 0d 0 0 14 4 40 1
C waiting 0 0
B 1 0a a1a1a1a1 00 0 00 0 00 0
I 1
E wakeAlu 1 11 1 10 0 a1a1a1a1 2
B 2 00 0 0b b2b2b2b2 00 0 00 0
I 1
E wakeMul 1 12 2 20 0 3 b2b2b2b2
B 4 00 0 00 0 0c c3c3c3c3 00 0
I 1
E wakeDiv 1 13 3 30 0 c3c3c3c3 4
B 8 00 0 00 0 00 0 0d d4d4d4d4
I 1
E wakeLoad 1 14 4 40 1 5 d4d4d4d4
B 7 20 c0ffee00 21 11110000 21 22220000 00 0
D 20 deadbeef 0 21 deadbeef 0 18 9 44 0
E bypass 1 18 9 44 0 c0ffee00 11110000
C bypassOnce 0 0
D 30 0 0 00 a0 1 20 2 100 0
D 30 0 0 00 a1 1 21 2 101 0
D 30 0 0 00 a2 1 22 2 102 0
D 30 0 0 00 a3 1 23 2 103 0
D 30 0 0 00 a4 1 24 2 104 0
D 30 0 0 00 a5 1 25 2 105 0
D 30 0 0 00 a6 1 26 2 106 0
D 30 0 0 00 a7 1 27 2 107 0
D 30 0 0 00 a8 1 28 2 108 0
D 30 0 0 00 a9 1 29 2 109 0
D 30 0 0 00 aa 1 2a 2 10a 0
D 30 0 0 00 ab 1 2b 2 10b 0
D 30 0 0 00 ac 1 2c 2 10c 0
D 30 0 0 00 ad 1 2d 2 10d 0
D 30 0 0 00 ae 1 2e 2 10e 0
D 30 0 0 00 af 1 2f 2 10f 0
C full 0 1
D 01 5 1 02 6 1 3f f 999 1
C dropped 0 1
B 8 00 0 00 0 00 0 30 0badf00d
I 1
E drain00 1 20 2 100 0 0badf00d a0
C notFull 1 0
E drain01 0 21 2 101 0 0badf00d a1
E drain02 0 22 2 102 0 0badf00d a2
E drain03 0 23 2 103 0 0badf00d a3
E drain04 0 24 2 104 0 0badf00d a4
E drain05 0 25 2 105 0 0badf00d a5
E drain06 0 26 2 106 0 0badf00d a6
E drain07 0 27 2 107 0 0badf00d a7
E drain08 0 28 2 108 0 0badf00d a8
E drain09 0 29 2 109 0 0badf00d a9
E drain0a 0 2a 2 10a 0 0badf00d aa
E drain0b 0 2b 2 10b 0 0badf00d ab
E drain0c 0 2c 2 10c 0 0badf00d ac
E drain0d 0 2d 2 10d 0 0badf00d ad
E drain0e 0 2e 2 10e 0 0badf00d ae
E drain0f 0 2f 2 10f 0 0badf00d af
C drained 0 0
I 3
C neverIssued 0 0

/* src.f */
rsPkg.sv
operandCapture.sv
rsEntryArray.sv
issueSelect.sv
reservationStation.sv
tbReservationStation.sv
